/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = bus_probe_tb
FILELIST = files.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* design/bus_comparator.sv */
`timescale 1ns/1ns

module bus_comparator
	import probe_pkg::*;
#(
	parameter int NUM_ROUTES = 8
) (
	input  logic                  pllclk,
	input  logic                  f_reset,
	input  sample_u               sample,
	input  logic [31:0]           atom,
	input  logic                  val_load,
	input  logic                  mask_load,
	input  logic                  level_load,
	input  logic                  edge_load,
	output logic [NUM_ROUTES-1:0] route_hit
);

	logic [SAMPLE_W-1:0]   cmp_val;
	logic [SAMPLE_W-1:0]   cmp_mask;
	logic [NUM_ROUTES-1:0] level_mask;
	logic [NUM_ROUTES-1:0] edge_mask;
	logic                  match;
	logic                  prev_match;

	assign match = ((sample.raw ^ cmp_val) & cmp_mask) == '0; // only masked bits count

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			cmp_val    <= '0;
			cmp_mask   <= '0;
			level_mask <= '0;
			edge_mask  <= '0;
			prev_match <= 1'b0;
		end else begin
			if (val_load)
				cmp_val <= atom[SAMPLE_W-1:0];
			if (mask_load)
				cmp_mask <= atom[SAMPLE_W-1:0];
			if (level_load)
				level_mask <= atom[NUM_ROUTES-1:0];
			if (edge_load)
				edge_mask <= atom[NUM_ROUTES-1:0];
			prev_match <= match;
		end
	end

	always_comb begin
		route_hit = '0;
		if (match) begin
			route_hit = level_mask;
			if (!prev_match)
				route_hit = route_hit | edge_mask; // first cycle of the match
		end
	end

	// host side must hold off config writes until the probe is out of reset
	a_no_load_in_reset: assert property (@(posedge pllclk)
		f_reset |-> !(val_load || mask_load || level_load || edge_load));

endmodule

/* design/bus_probe_top.sv */
`timescale 1ns/1ns

module bus_probe_top
	import probe_pkg::*;
#(
	parameter int NUM_ROUTES = 8,
	parameter int NUM_CMP    = 4,
	parameter int REC_AW     = 6
) (
	input  logic        pllclk,
	input  logic        f_reset,
	input  logic [15:0] host_adr,
	input  logic [7:0]  host_wdata,
	input  logic        host_wr,
	input  logic        host_rd,
	output logic [7:0]  host_rdata,
	input  logic [14:0] cart_adr,
	input  logic [7:0]  cart_data,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_cs_rom,
	input  logic        n_cs_xram,
	input  logic        phi,
	input  logic        n_cart_reset,
	input  logic [7:0]  pa_in,
	output logic [7:0]  pa_out
);

	sample_u               sample;
	logic [7:0]            pa_sync;
	logic [31:0]           atom;
	logic [NUM_ROUTES-1:0] route;
	logic [31:0]           rd_word;
	logic [REC_AW-1:0]     rd_index;
	logic                  ones_load;
	logic [NUM_CMP-1:0]    cmp_val_load;
	logic [NUM_CMP-1:0]    cmp_mask_load;
	logic [NUM_CMP-1:0]    trig_level_load;
	logic [NUM_CMP-1:0]    trig_edge_load;
	logic                  pa_set_load;
	logic                  pa_reset_load;
	logic                  pa_rt_set_load;
	logic                  pa_rt_reset_load;
	logic                  ptr_load;
	logic                  cap_load;

	bus_sampler u_sampler (
		.pllclk(pllclk), .f_reset(f_reset),
		.cart_adr(cart_adr), .cart_data(cart_data),
		.n_rd(n_rd), .n_wr(n_wr), .n_cs_rom(n_cs_rom), .n_cs_xram(n_cs_xram),
		.phi(phi), .n_cart_reset(n_cart_reset), .pa_in(pa_in),
		.sample(sample), .pa_sync(pa_sync)
	);

	trigger_unit #(.NUM_ROUTES(NUM_ROUTES), .NUM_CMP(NUM_CMP)) u_trigger (
		.pllclk(pllclk), .f_reset(f_reset), .sample(sample), .atom(atom),
		.ones_load(ones_load), .cmp_val_load(cmp_val_load), .cmp_mask_load(cmp_mask_load),
		.trig_level_load(trig_level_load), .trig_edge_load(trig_edge_load),
		.route(route)
	);

	port_a_driver #(.NUM_ROUTES(NUM_ROUTES)) u_port_a (
		.pllclk(pllclk), .f_reset(f_reset), .host_byte(host_wdata), .atom(atom),
		.pa_set_load(pa_set_load), .pa_reset_load(pa_reset_load),
		.pa_rt_set_load(pa_rt_set_load), .pa_rt_reset_load(pa_rt_reset_load),
		.route(route), .pa_out(pa_out)
	);

	trace_recorder #(.NUM_ROUTES(NUM_ROUTES), .REC_AW(REC_AW)) u_recorder (
		.pllclk(pllclk), .f_reset(f_reset), .sample(sample), .route(route), .atom(atom),
		.ptr_load(ptr_load), .cap_load(cap_load), .rd_index(rd_index), .rd_word(rd_word)
	);

	host_regs #(.REC_AW(REC_AW), .NUM_CMP(NUM_CMP)) u_host (
		.pllclk(pllclk), .f_reset(f_reset),
		.host_adr(host_adr), .host_wdata(host_wdata), .host_wr(host_wr), .host_rd(host_rd),
		.sample(sample), .pa_out(pa_out), .pa_sync(pa_sync), .rd_word(rd_word),
		.host_rdata(host_rdata), .atom(atom), .rd_index(rd_index),
		.ones_load(ones_load), .cmp_val_load(cmp_val_load), .cmp_mask_load(cmp_mask_load),
		.trig_level_load(trig_level_load), .trig_edge_load(trig_edge_load),
		.pa_set_load(pa_set_load), .pa_reset_load(pa_reset_load),
		.pa_rt_set_load(pa_rt_set_load), .pa_rt_reset_load(pa_rt_reset_load),
		.ptr_load(ptr_load), .cap_load(cap_load)
	);

endmodule

/* design/bus_sampler.sv */
`timescale 1ns/1ns

module bus_sampler
	import probe_pkg::*;
(
	input  logic        pllclk,
	input  logic        f_reset,
	input  logic [14:0] cart_adr,
	input  logic [7:0]  cart_data,
	input  logic        n_rd,
	input  logic        n_wr,
	input  logic        n_cs_rom,
	input  logic        n_cs_xram,
	input  logic        phi,
	input  logic        n_cart_reset,
	input  logic [7:0]  pa_in,
	output sample_u     sample,
	output logic [7:0]  pa_sync
);

	// cart_reset, phi, wr, rd, cs_xram, data, cs_rom, adr
	logic [28:0] bus_s1;
	logic [28:0] bus_s2;
	logic [7:0]  pa_s1;
	logic [7:0]  pa_s2;

	// two flop synchronizer, strobes flipped to active high on the way in
	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			bus_s1 <= '0;
			bus_s2 <= '0;
			pa_s1  <= '0;
			pa_s2  <= '0;
		end else begin
			bus_s1 <= {~n_cart_reset, phi, ~n_wr, ~n_rd, ~n_cs_xram, cart_data,
			           ~n_cs_rom, cart_adr};
			bus_s2 <= bus_s1;
			pa_s1  <= pa_in;
			pa_s2  <= pa_s1;
		end
	end

	always_comb begin
		sample.f.pa0        = pa_s2[0];
		sample.f.cart_reset = bus_s2[28];
		sample.f.phi        = bus_s2[27];
		sample.f.wr         = bus_s2[26];
		sample.f.rd         = bus_s2[25];
		sample.f.cs_xram    = bus_s2[24];
		sample.f.rsvd       = 1'b0; // was the data direction bit
		sample.f.data       = bus_s2[23:16];
		sample.f.cs_rom     = bus_s2[15];
		sample.f.adr        = bus_s2[14:0];
	end

	assign pa_sync = pa_s2;

endmodule

/* design/host_regs.sv */
`timescale 1ns/1ns

module host_regs
	import probe_pkg::*;
#(
	parameter int REC_AW  = 6,
	parameter int NUM_CMP = 4
) (
	input  logic               pllclk,
	input  logic               f_reset,
	input  logic [15:0]        host_adr,
	input  logic [7:0]         host_wdata,
	input  logic               host_wr,
	input  logic               host_rd,
	input  sample_u            sample,
	input  logic [7:0]         pa_out,
	input  logic [7:0]         pa_sync,
	input  logic [31:0]        rd_word,
	output logic [7:0]         host_rdata,
	output logic [31:0]        atom,
	output logic [REC_AW-1:0]  rd_index,
	output logic               ones_load,
	output logic [NUM_CMP-1:0] cmp_val_load,
	output logic [NUM_CMP-1:0] cmp_mask_load,
	output logic [NUM_CMP-1:0] trig_level_load,
	output logic [NUM_CMP-1:0] trig_edge_load,
	output logic               pa_set_load,
	output logic               pa_reset_load,
	output logic               pa_rt_set_load,
	output logic               pa_rt_reset_load,
	output logic               ptr_load,
	output logic               cap_load
);

	logic       cs_atom;
	logic       cs_ones;
	logic       cs_rec;
	logic       cs_pa;
	logic       cs_cart;
	logic       cs_recram;
	logic [1:0] adr_sel;
	logic       wr_pa;
	logic       wr_cart;
	logic [7:0] rd_mux;
	logic [7:0] rd_byte;
	logic       rd_ram;
	logic [1:0] rd_sel;

	assign adr_sel   = host_adr[1:0];
	assign cs_atom   = host_adr[15:2] == ADR_ATOM[15:2];
	assign cs_ones   = host_adr == ADR_ONES;
	assign cs_rec    = host_adr == ADR_REC;
	assign cs_pa     = host_adr[15:2] == ADR_PA[15:2];
	assign cs_cart   = host_adr[15:2] == ADR_CART[15:2];
	assign cs_recram = host_adr[15:12] == ADR_RECRAM;

	assign rd_index = host_adr[REC_AW+1:2]; // ram word, byte picked after the read

	assign wr_pa   = host_wr && cs_pa;
	assign wr_cart = host_wr && cs_cart;

	assign ones_load        = host_wr && cs_ones;
	assign ptr_load         = host_wr && cs_rec && host_wdata[0];
	assign cap_load         = host_wr && cs_rec && host_wdata[1];
	assign pa_set_load      = wr_pa && adr_sel == 2'd0;
	assign pa_reset_load    = wr_pa && adr_sel == 2'd1;
	assign pa_rt_set_load   = wr_pa && adr_sel == 2'd2 && host_wdata == 8'd1;
	assign pa_rt_reset_load = wr_pa && adr_sel == 2'd3 && host_wdata == 8'd1;

	// low nibble selects comparators for one mask, high nibble for the other
	assign trig_level_load = (wr_cart && adr_sel == 2'd1) ? host_wdata[NUM_CMP-1:0] : '0;
	assign trig_edge_load  = (wr_cart && adr_sel == 2'd1) ? host_wdata[NUM_CMP+3:4] : '0;
	assign cmp_val_load    = (wr_cart && adr_sel == 2'd3) ? host_wdata[NUM_CMP-1:0] : '0;
	assign cmp_mask_load   = (wr_cart && adr_sel == 2'd3) ? host_wdata[NUM_CMP+3:4] : '0;

	always_ff @(posedge pllclk) begin
		if (host_wr && cs_atom)
			atom[8*adr_sel +: 8] <= host_wdata;
	end

	always_comb begin
		rd_mux = BYTE_FF;
		if (cs_atom) begin
			rd_mux = atom[8*adr_sel +: 8];
		end else if (cs_pa) begin
			if (adr_sel == 2'd0)
				rd_mux = pa_out;
			else if (adr_sel == 2'd1)
				rd_mux = pa_sync;
		end else if (cs_cart) begin
			case (adr_sel)
				2'd0: rd_mux = sample.raw[7:0];
				2'd1: rd_mux = sample.raw[15:8];
				2'd2: rd_mux = sample.raw[23:16];
				default: rd_mux = {1'b0, sample.f.pa0, sample.f.cart_reset, sample.f.phi,
				                   sample.f.wr, sample.f.rd, sample.f.cs_xram, sample.f.rsvd};
			endcase
		end
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			rd_byte <= BYTE_FF;
			rd_ram  <= 1'b0;
			rd_sel  <= 2'd0;
		end else if (host_rd) begin
			rd_byte <= rd_mux;
			rd_ram  <= cs_recram;
			rd_sel  <= adr_sel;
		end
	end

	// recorder word shows up together with the registered bytes
	assign host_rdata = rd_ram ? rd_word[8*rd_sel +: 8] : rd_byte;

	a_no_wr_rd: assert property (@(posedge pllclk) disable iff (f_reset)
		!(host_wr && host_rd));

endmodule

/* design/port_a_driver.sv */
`timescale 1ns/1ns

module port_a_driver #(
	parameter int NUM_ROUTES = 8
) (
	input  logic                  pllclk,
	input  logic                  f_reset,
	input  logic [7:0]            host_byte,
	input  logic [31:0]           atom,
	input  logic                  pa_set_load,
	input  logic                  pa_reset_load,
	input  logic                  pa_rt_set_load,
	input  logic                  pa_rt_reset_load,
	input  logic [NUM_ROUTES-1:0] route,
	output logic [7:0]            pa_out
);

	logic [7:0]            set_mask;
	logic [7:0]            reset_mask;
	logic [NUM_ROUTES-1:0] rt_set_mask;
	logic [NUM_ROUTES-1:0] rt_reset_mask;
	logic [7:0]            set_eff;
	logic [7:0]            reset_eff;

	always_comb begin
		set_eff      = set_mask;
		reset_eff    = reset_mask;
		set_eff[0]   = set_mask[0] | (|(route & rt_set_mask)); // only bit 0 follows routes
		reset_eff[0] = reset_mask[0] | (|(route & rt_reset_mask));
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			set_mask      <= '0;
			reset_mask    <= '0;
			rt_set_mask   <= '0;
			rt_reset_mask <= '0;
			pa_out        <= '0;
		end else begin
			if (pa_set_load)
				set_mask <= host_byte;
			if (pa_reset_load)
				reset_mask <= host_byte;
			if (pa_rt_set_load)
				rt_set_mask <= atom[NUM_ROUTES-1:0];
			if (pa_rt_reset_load)
				rt_reset_mask <= atom[NUM_ROUTES-1:0];
			pa_out <= (pa_out | set_eff) & ~reset_eff; // clear wins
		end
	end

endmodule

/* design/probe_pkg.sv */
package probe_pkg;

	localparam int SAMPLE_W = 31;

	// host register map
	localparam logic [15:0] ADR_ATOM = 16'hff10; // four bytes, low first
	localparam logic [15:0] ADR_ONES = 16'hff14;
	localparam logic [15:0] ADR_REC  = 16'hff15;
	localparam logic [15:0] ADR_PA   = 16'hff40;
	localparam logic [15:0] ADR_CART = 16'hff50;

	localparam logic [3:0] ADR_RECRAM = 4'h2; // 0x2000-0x2fff, top nibble only

	localparam logic [7:0] BYTE_FF = 8'hff; // idle read value

	// strobes are already active high here
	typedef struct packed {
		logic       pa0;
		logic       cart_reset;
		logic       phi;
		logic       wr;
		logic       rd;
		logic       cs_xram;
		logic       rsvd;
		logic [7:0] data;
		logic       cs_rom;
		logic [14:0] adr;
	} cart_fields_t;

	typedef union packed {
		logic [SAMPLE_W-1:0] raw; // compare and record view
		cart_fields_t        f;
	} sample_u;

endpackage

/* design/trace_recorder.sv */
`timescale 1ns/1ns

module trace_recorder
	import probe_pkg::*;
#(
	parameter int NUM_ROUTES = 8,
	parameter int REC_AW     = 6
) (
	input  logic                  pllclk,
	input  logic                  f_reset,
	input  sample_u               sample,
	input  logic [NUM_ROUTES-1:0] route,
	input  logic [31:0]           atom,
	input  logic                  ptr_load,
	input  logic                  cap_load,
	input  logic [REC_AW-1:0]     rd_index,
	output logic [31:0]           rd_word
);

	logic [31:0]           ram [2**REC_AW];
	logic [REC_AW-1:0]     wr_ptr;
	logic [NUM_ROUTES-1:0] cap_mask;
	logic                  capture;

	initial begin
		for (int i = 0; i < 2**REC_AW; i++)
			ram[i] = '0; // ram powers up cleared
	end

	assign capture = |(route & cap_mask) && !ptr_load;

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			wr_ptr   <= '0;
			cap_mask <= '0;
		end else begin
			if (cap_load)
				cap_mask <= atom[NUM_ROUTES-1:0];
			if (ptr_load)
				wr_ptr <= atom[REC_AW-1:0];
			else if (capture)
				wr_ptr <= wr_ptr + 1'b1; // wraps
		end
	end

	always_ff @(posedge pllclk) begin
		if (capture)
			ram[wr_ptr] <= {1'b0, sample.raw};
		rd_word <= ram[rd_index];
	end

	a_ptr_known: assert property (@(posedge pllclk) disable iff (f_reset)
		!$isunknown(wr_ptr));

endmodule

/* design/trigger_unit.sv */
`timescale 1ns/1ns

module trigger_unit
	import probe_pkg::*;
#(
	parameter int NUM_ROUTES = 8,
	parameter int NUM_CMP    = 4
) (
	input  logic                  pllclk,
	input  logic                  f_reset,
	input  sample_u               sample,
	input  logic [31:0]           atom,
	input  logic                  ones_load,
	input  logic [NUM_CMP-1:0]    cmp_val_load,
	input  logic [NUM_CMP-1:0]    cmp_mask_load,
	input  logic [NUM_CMP-1:0]    trig_level_load,
	input  logic [NUM_CMP-1:0]    trig_edge_load,
	output logic [NUM_ROUTES-1:0] route
);

	logic [NUM_ROUTES-1:0] ones_mask;
	logic [NUM_ROUTES-1:0] hits [NUM_CMP];
	logic [NUM_ROUTES-1:0] route_next;

	for (genvar i = 0; i < NUM_CMP; i++) begin : g_cmp
		bus_comparator #(
			.NUM_ROUTES(NUM_ROUTES)
		) u_cmp (
			.pllclk    (pllclk),
			.f_reset   (f_reset),
			.sample    (sample),
			.atom      (atom),
			.val_load  (cmp_val_load[i]),
			.mask_load (cmp_mask_load[i]),
			.level_load(trig_level_load[i]),
			.edge_load (trig_edge_load[i]),
			.route_hit (hits[i])
		);
	end

	always_comb begin
		route_next = ones_mask;
		for (int i = 0; i < NUM_CMP; i++)
			route_next = route_next | hits[i];
	end

	always_ff @(posedge pllclk) begin
		if (f_reset) begin
			ones_mask <= '0;
			route     <= '0;
		end else begin
			if (ones_load)
				ones_mask <= atom[NUM_ROUTES-1:0];
			route <= route_next;
		end
	end

endmodule

/* files.f */
design/probe_pkg.sv
design/bus_sampler.sv
design/bus_comparator.sv
design/trigger_unit.sv
design/port_a_driver.sv
design/trace_recorder.sv
design/host_regs.sv
design/bus_probe_top.sv
verif/tb_clock.sv
verif/bus_probe_tb.sv

/* verif/bus_probe_tb.sv */
`timescale 1ns/1ns

module bus_probe_tb
	import probe_pkg::*;
();

	localparam int NUM_ROUTES = 8;
	localparam int NUM_CMP    = 4;
	localparam int REC_AW     = 6;
	localparam int REC_DEPTH  = 2**REC_AW;
	localparam int WATCHDOG   = 20000; // cycles

	logic        pllclk;
	logic        f_reset;
	logic [15:0] host_adr;
	logic [7:0]  host_wdata;
	logic        host_wr;
	logic        host_rd;
	logic [7:0]  host_rdata;
	logic [14:0] cart_adr;
	logic [7:0]  cart_data;
	logic        n_rd;
	logic        n_wr;
	logic        n_cs_rom;
	logic        n_cs_xram;
	logic        phi;
	logic        n_cart_reset;
	logic [7:0]  pa_in;
	logic [7:0]  pa_out;

	int seed = 55181;
	int checks = 0;
	int errors = 0;
	int timeouts = 0;

	tb_clock #(.PERIOD(100), .RESET_CYCLES(3)) u_clk (.pllclk(pllclk), .f_reset(f_reset));

	bus_probe_top #(.NUM_ROUTES(NUM_ROUTES), .NUM_CMP(NUM_CMP), .REC_AW(REC_AW)) UUT (
		.pllclk(pllclk), .f_reset(f_reset),
		.host_adr(host_adr), .host_wdata(host_wdata), .host_wr(host_wr), .host_rd(host_rd),
		.host_rdata(host_rdata),
		.cart_adr(cart_adr), .cart_data(cart_data), .n_rd(n_rd), .n_wr(n_wr),
		.n_cs_rom(n_cs_rom), .n_cs_xram(n_cs_xram), .phi(phi), .n_cart_reset(n_cart_reset),
		.pa_in(pa_in), .pa_out(pa_out)
	);

	task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("CHECK FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
		end
	endtask

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++)
			@(posedge pllclk);
	endtask

	task automatic wait_reset_release();
		int cnt;
		cnt = 0;
		@(posedge pllclk);
		while (f_reset !== 1'b0 && cnt < 20) begin
			@(posedge pllclk);
			cnt++;
		end
		if (f_reset !== 1'b0) begin
			timeouts++;
			$display("timeout: reset was never released");
		end
	endtask

	task automatic wait_pa0(input logic exp, input int limit);
		int cnt;
		cnt = 0;
		while (pa_out[0] !== exp && cnt < limit) begin
			@(posedge pllclk);
			cnt++;
		end
		if (pa_out[0] !== exp) begin
			timeouts++;
			$display("timeout: port A bit 0 did not reach %0b in %0d cycles", exp, limit);
		end
	endtask

	task automatic host_write(input logic [15:0] adr, input logic [7:0] data);
		@(posedge pllclk);
		host_adr   <= adr;
		host_wdata <= data;
		host_wr    <= 1'b1;
		@(posedge pllclk);
		host_wr    <= 1'b0;
	endtask

	// data is valid for the whole cycle after the read strobe
	task automatic host_read(input logic [15:0] adr, output logic [7:0] data);
		@(posedge pllclk);
		host_adr <= adr;
		host_rd  <= 1'b1;
		@(posedge pllclk);
		host_rd  <= 1'b0;
		@(negedge pllclk);
		data = host_rdata;
	endtask

	task automatic load_atom(input logic [31:0] v);
		for (int i = 0; i < 4; i++)
			host_write(ADR_ATOM + 16'(i), v[8*i +: 8]);
	endtask

	task automatic read_cart_word(output logic [31:0] w);
		logic [7:0] b;
		for (int i = 0; i < 4; i++) begin
			host_read(ADR_CART + 16'(i), b);
			w[8*i +: 8] = b;
		end
	endtask

	task automatic read_ram_word(input int idx, output logic [31:0] w);
		logic [7:0]  b;
		logic [15:0] a;
		for (int i = 0; i < 4; i++) begin
			a = {ADR_RECRAM, 12'(idx*4 + i)}; // entry in bits 11:2 and byte in 1:0
			host_read(a, b);
			w[8*i +: 8] = b;
		end
	endtask

	task automatic randomize_pins();
		logic [31:0] r1;
		logic [31:0] r2;
		r1 = $random(seed);
		r2 = $random(seed);
		@(posedge pllclk);
		cart_adr     <= r1[14:0];
		cart_data    <= r1[22:15];
		n_rd         <= r1[23];
		n_wr         <= r1[24];
		n_cs_rom     <= r1[25];
		n_cs_xram    <= r1[26];
		phi          <= r1[27];
		n_cart_reset <= r1[28];
		pa_in        <= r2[7:0];
	endtask

	// drives the pins so that the packed sample becomes s
	task automatic apply_sample(input logic [30:0] s);
		logic [31:0] r;
		r = $random(seed);
		@(posedge pllclk);
		pa_in        <= {r[6:0], s[30]};
		n_cart_reset <= ~s[29];
		phi          <= s[28];
		n_wr         <= ~s[27];
		n_rd         <= ~s[26];
		n_cs_xram    <= ~s[25];
		cart_data    <= s[23:16];
		n_cs_rom     <= ~s[15];
		cart_adr     <= s[14:0];
	endtask

	task automatic check_pa(input string name, input logic [7:0] exp);
		wait_pa0(exp[0], 12);
		wait_cycles(6);
		compare_word(name, exp, pa_out);
	endtask

	function automatic logic [30:0] expected_sample();
		return {pa_in[0], ~n_cart_reset, phi, ~n_wr, ~n_rd, ~n_cs_xram, 1'b0, cart_data,
		        ~n_cs_rom, cart_adr};
	endfunction

	function automatic logic [30:0] random_sample();
		logic [31:0] r;
		r = $random(seed);
		return r[30:0] & 31'h7eff_ffff; // reserved bit stays zero
	endfunction

	function automatic logic [30:0] match_sample(input logic [30:0] v, input logic [30:0] m);
		return (v & m) | (random_sample() & ~m);
	endfunction

	function automatic logic is_mapped(input logic [15:0] a);
		return a[15:12] == ADR_RECRAM || (a >= ADR_ATOM && a <= ADR_REC) ||
		       (a >= ADR_PA && a <= ADR_PA + 16'd3) || (a >= ADR_CART && a <= ADR_CART + 16'd3);
	endfunction

	initial begin
		logic [31:0] word;
		logic [31:0] expw;
		logic [30:0] v_cmp;
		logic [30:0] m_cmp;
		logic [30:0] s;
		logic [30:0] ns;
		logic [30:0] edge_s [8];
		logic [15:0] adr;
		logic [7:0]  b;
		logic [7:0]  pa_model;
		logic [7:0]  smask;
		logic [7:0]  rmask;
		logic [7:0]  rm_cur;
		int          r;
		int          n_edge;

		host_adr     = '0;
		host_wdata   = '0;
		host_wr      = 1'b0;
		host_rd      = 1'b0;
		cart_adr     = '0;
		cart_data    = '0;
		n_rd         = 1'b1;
		n_wr         = 1'b1;
		n_cs_rom     = 1'b1;
		n_cs_xram    = 1'b1;
		phi          = 1'b0;
		n_cart_reset = 1'b1;
		pa_in        = '0;

		wait_reset_release();
		wait_cycles(2);
		compare_word("reset rdata", BYTE_FF, host_rdata);

		// atom read back and unmapped reads
		for (int i = 0; i < 4; i++) begin
			b = $random(seed);
			expw[8*i +: 8] = b;
			host_write(ADR_ATOM + 16'(i), b);
		end
		for (int i = 0; i < 4; i++) begin
			host_read(ADR_ATOM + 16'(i), b);
			compare_word($sformatf("atom byte %0d", i), expw[8*i +: 8], b);
		end
		for (int k = 0; k < 8; k++) begin
			do
				adr = $random(seed);
			while (is_mapped(adr));
			host_read(adr, b);
			compare_word($sformatf("unmapped read 0x%h", adr), BYTE_FF, b);
		end

		// sample packing
		for (int k = 0; k < 6; k++) begin
			randomize_pins();
			wait_cycles(5);
			read_cart_word(word);
			compare_word($sformatf("sample packing %0d", k), {1'b0, expected_sample()}, word);
			host_read(ADR_PA + 16'd1, b);
			compare_word($sformatf("pa sync %0d", k), pa_in, b);
		end

		// port A held masks
		pa_model = '0;
		rm_cur   = '0;
		for (int k = 0; k < 3; k++) begin
			smask = $random(seed);
			rmask = $random(seed);
			host_write(ADR_PA, smask);
			pa_model = (pa_model | smask) & ~rm_cur;
			host_write(ADR_PA + 16'd1, rmask);
			rm_cur   = rmask;
			pa_model = (pa_model | smask) & ~rmask;
			wait_cycles(3);
			compare_word($sformatf("pa masks %0d", k), pa_model, pa_out);
			host_read(ADR_PA, b);
			compare_word($sformatf("pa read %0d", k), pa_model, b);
		end
		host_write(ADR_PA, 8'h00);
		host_write(ADR_PA + 16'd1, 8'hff);
		host_write(ADR_PA + 16'd1, 8'h00);
		pa_model = '0;
		wait_cycles(2);
		compare_word("pa cleared", pa_model, pa_out);

		// level trigger on comparator 0 driving port A bit 0 through route 0
		v_cmp = random_sample();
		m_cmp = $random(seed);
		m_cmp[0] = 1'b1; // flipping adr bit 0 always breaks the match
		s  = match_sample(v_cmp, m_cmp);
		ns = s ^ 31'h1;
		apply_sample(ns);
		wait_cycles(4);
		load_atom({1'b0, v_cmp});
		host_write(ADR_CART + 16'd3, 8'h01);
		load_atom({1'b0, m_cmp});
		host_write(ADR_CART + 16'd3, 8'h10);
		load_atom(32'h1);
		host_write(ADR_CART + 16'd1, 8'h01);
		host_write(ADR_PA + 16'd2, 8'h01);
		check_pa("level idle", 8'h00);
		apply_sample(s);
		check_pa("level match", 8'h01);
		apply_sample(ns);
		check_pa("level hold", 8'h01);
		host_write(ADR_PA + 16'd1, 8'h01);
		check_pa("level reset mask", 8'h00);
		apply_sample(s);
		check_pa("level reset wins", 8'h00);
		host_write(ADR_PA + 16'd1, 8'h00);
		check_pa("level match again", 8'h01);
		apply_sample(ns);
		host_write(ADR_PA + 16'd1, 8'h01);
		host_write(ADR_PA + 16'd1, 8'h00);
		check_pa("level cleared", 8'h00);
		load_atom(32'h0);
		host_write(ADR_CART + 16'd1, 8'h01);
		host_write(ADR_PA + 16'd2, 8'h01);

		// edge trigger into the recorder
		r = 1 + {$random(seed)} % 7;
		load_atom(32'h1 << r);
		host_write(ADR_CART + 16'd1, 8'h10);
		host_write(ADR_REC, 8'h02);
		load_atom(32'h0);
		host_write(ADR_REC, 8'h01);
		n_edge = 3 + {$random(seed)} % 4;
		for (int k = 0; k < n_edge; k++) begin
			edge_s[k] = match_sample(v_cmp, m_cmp);
			apply_sample(edge_s[k]);
			wait_cycles(8);
			apply_sample(edge_s[k] ^ 31'h1);
			wait_cycles(8);
		end
		for (int k = 0; k < n_edge; k++) begin
			read_ram_word(k, word);
			compare_word($sformatf("edge entry %0d", k), {1'b0, edge_s[k]}, word);
		end
		read_ram_word(n_edge, word);
		compare_word("entry after last edge", 32'h0, word);

		// ones mask keeps the capture route high so the ram fills and wraps
		s = random_sample();
		apply_sample(s);
		wait_cycles(4);
		load_atom(32'h1 << r);
		host_write(ADR_ONES, 8'h00);
		wait_cycles(REC_DEPTH + 8);
		load_atom(32'h0);
		host_write(ADR_ONES, 8'h00);
		wait_cycles(4);
		for (int k = 0; k < REC_DEPTH; k++) begin
			read_ram_word(k, word);
			compare_word($sformatf("ones entry %0d", k), {1'b0, s}, word);
		end

		$display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		for (int c = 0; c < WATCHDOG; c++)
			@(posedge pllclk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG);
		$display("checks %0d, value errors %0d, timeouts %0d", checks, errors, timeouts + 1);
		$display("Result: FAILED");
		$finish;
	end

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic pllclk,
	output logic f_reset
);

	initial begin
		pllclk = 1'b0;
		forever #(PERIOD/2) pllclk = ~pllclk;
	end

	initial begin
		f_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge pllclk);
		f_reset <= 1'b0; // released on an edge like the rest of the stimulus
	end

endmodule
